// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module rv_exec_tb -o rv_exec_sim
	out=$$(./obj_dir/rv_exec_sim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// ==== logic/rv_apb_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_apb_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic [11:0]        paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  rv_pkg::word_t      pwdata,
    output rv_pkg::word_t      prdata,
    output logic               pready,
    output logic               pslverr,
    output rv_pkg::reg_addr_t  rs_addr_a,
    output rv_pkg::reg_addr_t  rs_addr_b,
    input  rv_pkg::reg_addr_t  dec_rs1,
    input  rv_pkg::reg_addr_t  dec_rs2,
    input  rv_pkg::word_t      rs_data_a,
    output logic               wr_en,
    output rv_pkg::reg_addr_t  wr_addr,
    output rv_pkg::word_t      wr_data,
    output rv_pkg::word_t      pc,
    input  rv_pkg::exu_out_t   exu_out
);
    import rv_pkg::*;

    word_t     last_instr;
    reg_addr_t reg_idx;
    logic      access;
    logic      is_instr;
    logic      is_pc;
    logic      is_reg;
    logic      commit;
    logic      host_reg_wr;

    assign access   = psel && penable;
    assign is_instr = (paddr == addr_instr);
    assign is_pc    = (paddr == addr_pc);
    assign is_reg   = (paddr[11:7] == addr_reg_base[11:7]) && (paddr[1:0] == 2'b00);
    assign reg_idx  = paddr[6:2];

    assign commit      = access && pwrite && is_instr && !exu_out.trap;
    assign host_reg_wr = access && pwrite && is_reg;

    assign rs_addr_a = (is_instr && pwrite) ? dec_rs1 : reg_idx;
    assign rs_addr_b = dec_rs2;

    // One write port shared by execute and host
    assign wr_en   = (commit && exu_out.reg_write) || host_reg_wr;
    assign wr_addr = commit ? exu_out.rd : reg_idx;
    assign wr_data = commit ? exu_out.result : pwdata;

    assign pready  = access; // No wait states
    assign pslverr = access && (!(is_instr || is_pc || is_reg) ||
                                (is_instr && pwrite && exu_out.trap));

    always_comb begin
        if (is_instr) prdata = last_instr;
        else if (is_pc) prdata = pc;
        else if (is_reg) prdata = rs_data_a;
        else prdata = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            last_instr <= '0;
        end else if (commit) begin
            pc         <= exu_out.next_pc;
            last_instr <= pwdata;
        end else if (access && pwrite && is_pc) begin
            pc <= pwdata;
        end
    end

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> psel) else $error("penable rose without psel");

    // Host leaves the access cycle after one clock
    a_single_access: assert property (@(posedge clk) disable iff (rst)
        (psel && penable) |=> !penable) else $error("access cycle held past pready");

endmodule

`default_nettype wire

// ==== logic/rv_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decoder (
    input  rv_pkg::word_t instr,
    output rv_pkg::dec_t  dec
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_b;
    word_t      imm_sh;
    logic       opcode_ok;
    logic       funct_ok;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_u  = {instr[31:12], 12'b0};
    assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_sh = {27'b0, instr[24:20]}; // Shift amount only

    always_comb begin
        dec.opcode    = opcode;
        dec.funct3    = funct3;
        dec.funct7    = funct7;
        dec.rd        = instr[11:7];
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        dec.imm       = '0;
        dec.reg_write = 1'b0;
        opcode_ok     = 1'b1;
        funct_ok      = 1'b1;
        case (opcode)
            op_imm: begin
                dec.reg_write = 1'b1;
                if (funct3 == 3'b001) begin
                    dec.imm  = imm_sh;
                    funct_ok = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    dec.imm  = imm_sh;
                    funct_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    dec.imm = imm_i;
                end
            end
            op_reg: begin
                dec.reg_write = 1'b1;
                case (funct7)
                    7'b0000000: funct_ok = 1'b1;
                    7'b0100000: funct_ok = (funct3 == 3'b000) || (funct3 == 3'b101); // SUB, SRA
                    7'b0000001: funct_ok = (funct3 != 3'b010) && (funct3 != 3'b011); // No MULHSU/MULHU
                    default:    funct_ok = 1'b0;
                endcase
            end
            op_lui, op_auipc: begin
                dec.imm       = imm_u;
                dec.reg_write = 1'b1;
            end
            op_jal: begin
                dec.imm       = imm_j;
                dec.reg_write = 1'b1;
            end
            op_jalr: begin
                dec.imm       = imm_i;
                dec.reg_write = 1'b1;
                funct_ok      = (funct3 == 3'b000);
            end
            op_branch: begin
                dec.imm  = imm_b;
                funct_ok = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            default: opcode_ok = 1'b0; // Loads, stores, SYSTEM and the rest
        endcase
        dec.invalid = !opcode_ok || !funct_ok;
    end

endmodule

`default_nettype wire

// ==== logic/rv_exec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_exec_top (
    input  logic          clk,
    input  logic          rst,
    input  logic [11:0]   paddr,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  rv_pkg::word_t pwdata,
    output rv_pkg::word_t prdata,
    output logic          pready,
    output logic          pslverr
);
    import rv_pkg::*;

    dec_t      dec;
    exu_out_t  exu_out;
    reg_addr_t rs_addr_a;
    reg_addr_t rs_addr_b;
    reg_addr_t wr_addr;
    word_t     rs_data_a;
    word_t     rs_data_b;
    word_t     wr_data;
    word_t     pc;
    logic      wr_en;

    rv_apb_ctrl rv_apb_ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .rs_addr_a (rs_addr_a),
        .rs_addr_b (rs_addr_b),
        .dec_rs1   (dec.rs1),
        .dec_rs2   (dec.rs2),
        .rs_data_a (rs_data_a),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .pc        (pc),
        .exu_out   (exu_out)
    );

    rv_decoder rv_decoder_i (
        .instr (pwdata), // Instruction word straight off the bus
        .dec   (dec)
    );

    rv_regfile rv_regfile_i (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (rs_addr_a),
        .rd_addr_b (rs_addr_b),
        .rd_data_a (rs_data_a),
        .rd_data_b (rs_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    rv_exu rv_exu_i (
        .dec      (dec),
        .rs1_data (rs_data_a),
        .rs2_data (rs_data_b),
        .pc       (pc),
        .exu_out  (exu_out)
    );

endmodule

`default_nettype wire

// ==== logic/rv_exu.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_exu (
    input  rv_pkg::dec_t     dec,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    input  rv_pkg::word_t    pc,
    output rv_pkg::exu_out_t exu_out
);
    import rv_pkg::*;

    word_t              op_a;
    word_t              op_b;
    word_t              alu_out;
    word_t              pc_plus4;
    word_t              next_pc;
    logic [4:0]         shamt;
    logic signed [63:0] mul_full;
    logic               div_zero;
    logic               div_ovf;
    logic               branch_taken;

    always_comb begin
        case (dec.opcode)
            op_auipc, op_jal: op_a = pc;
            op_lui:           op_a = '0;
            default:          op_a = rs1_data;
        endcase
        case (dec.opcode)
            op_reg, op_branch: op_b = rs2_data;
            default:           op_b = dec.imm;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;
    assign shamt    = op_b[4:0]; // imm holds shamt for shift immediates
    assign mul_full = $signed(op_a) * $signed(op_b);
    assign div_zero = (op_b == '0);
    assign div_ovf  = (op_a == 32'h8000_0000) && (op_b == 32'hFFFF_FFFF);

    always_comb begin
        alu_out = '0;
        case (dec.opcode)
            op_lui:          alu_out = op_b;
            op_auipc:        alu_out = op_a + op_b;
            op_jal, op_jalr: alu_out = pc_plus4; // Link value
            op_imm, op_reg: begin
                if ((dec.opcode == op_reg) && (dec.funct7 == 7'b0000001)) begin
                    case (dec.funct3)
                        3'b000: alu_out = mul_full[31:0];
                        3'b001: alu_out = mul_full[63:32];
                        3'b100: begin // DIV
                            if (div_zero) alu_out = 32'hFFFF_FFFF;
                            else if (div_ovf) alu_out = 32'h8000_0000;
                            else alu_out = $signed(op_a) / $signed(op_b);
                        end
                        3'b101: alu_out = div_zero ? 32'hFFFF_FFFF : op_a / op_b;
                        3'b110: begin // REM
                            if (div_zero) alu_out = op_a;
                            else if (div_ovf) alu_out = '0;
                            else alu_out = $signed(op_a) % $signed(op_b);
                        end
                        3'b111: alu_out = div_zero ? op_a : op_a % op_b;
                        default: alu_out = '0;
                    endcase
                end else begin
                    case (dec.funct3)
                        3'b000: begin
                            if ((dec.opcode == op_reg) && dec.funct7[5]) alu_out = op_a - op_b;
                            else alu_out = op_a + op_b;
                        end
                        3'b001: alu_out = op_a << shamt;
                        3'b010: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
                        3'b011: alu_out = {31'b0, op_a < op_b};
                        3'b100: alu_out = op_a ^ op_b;
                        3'b101: begin
                            if (dec.funct7[5]) alu_out = $signed(op_a) >>> shamt;
                            else alu_out = op_a >> shamt;
                        end
                        3'b110: alu_out = op_a | op_b;
                        default: alu_out = op_a & op_b;
                    endcase
                end
            end
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  branch_taken = (rs1_data == rs2_data);
            3'b001:  branch_taken = (rs1_data != rs2_data);
            3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  branch_taken = (rs1_data < rs2_data);
            3'b111:  branch_taken = (rs1_data >= rs2_data);
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            op_jal:    next_pc = pc + dec.imm;
            op_jalr:   next_pc = (rs1_data + dec.imm) & ~32'h1;
            op_branch: next_pc = branch_taken ? pc + dec.imm : pc_plus4;
            default:   next_pc = pc_plus4;
        endcase
        // A misaligned PC from the host trips this too
        a_next_pc_even: assert (!next_pc[0]) else $error("next_pc bit 0 set");
    end

    assign exu_out.result    = alu_out;
    assign exu_out.rd        = dec.rd;
    assign exu_out.reg_write = dec.reg_write && !dec.invalid;
    assign exu_out.trap      = dec.invalid;
    assign exu_out.next_pc   = next_pc;

endmodule

`default_nettype wire

// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // Major opcodes
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;

    // APB register map
    localparam logic [11:0] addr_instr    = 12'h000;
    localparam logic [11:0] addr_pc       = 12'h004;
    localparam logic [11:0] addr_reg_base = 12'h080; // x0 to x31 up to 0x0FC

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
        logic       reg_write;
        logic       invalid;
    } dec_t;

    typedef struct packed {
        word_t      result;
        reg_addr_t  rd;
        logic       reg_write; // Already masked by trap
        logic       trap;
        word_t      next_pc;
    } exu_out_t;

endpackage

`default_nettype wire

// ==== logic/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rd_addr_a,
    input  rv_pkg::reg_addr_t rd_addr_b,
    output rv_pkg::word_t     rd_data_a,
    output rv_pkg::word_t     rd_data_b,
    input  logic              wr_en,
    input  rv_pkg::reg_addr_t wr_addr,
    input  rv_pkg::word_t     wr_data
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin // x0 stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        ((rd_addr_a == '0) |-> (rd_data_a == '0)) and ((rd_addr_b == '0) |-> (rd_data_b == '0)))
        else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// ==== sim.f ====
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_exu.sv
logic/rv_apb_ctrl.sv
logic/rv_exec_top.sv
test/rv_exec_tb.sv

// ==== test/rv_exec_stimulus.txt ====
# cmd addr data err : W writes data and checks pslverr against err
# R reads and checks prdata against data and pslverr against err
# reset state
R 004 00000000 0
R 084 00000000 0
R 0FC 00000000 0
# operands x1=7 x2=-16 x3=0x80000000 x4=-1 x24 preset
W 084 00000007 0
W 088 FFFFFFF0 0
W 08C 80000000 0
W 090 FFFFFFFF 0
W 0E0 12345678 0
# addi sub slt sltu xori or andi slli srai srl
W 000 FFD08513 0
R 0A8 00000004 0
W 000 402085B3 0
R 0AC 00000017 0
W 000 00112633 0
R 0B0 00000001 0
W 000 0020B6B3 0
R 0B4 00000001 0
W 000 0FF14713 0
R 0B8 FFFFFF0F 0
W 000 0020E7B3 0
R 0BC FFFFFFF7 0
W 000 0F717813 0
R 0C0 000000F0 0
W 000 00409893 0
R 0C4 00000070 0
W 000 4041D913 0
R 0C8 F8000000 0
W 000 0011D9B3 0
R 0CC 01000000 0
R 004 00000028 0
# mul mulh div div-overflow rem-overflow divu-by-zero remu-by-zero rem
W 000 02208A33 0
R 0D0 FFFFFF90 0
W 000 02319AB3 0
R 0D4 40000000 0
W 000 02114B33 0
R 0D8 FFFFFFFE 0
W 000 0241CBB3 0
R 0DC 80000000 0
W 000 0241EC33 0
R 0E0 00000000 0
W 000 0250DCB3 0
R 0E4 FFFFFFFF 0
W 000 0250FD33 0
R 0E8 00000007 0
W 000 02116DB3 0
R 0EC FFFFFFFE 0
R 004 00000048 0
# lui auipc jal jalr
W 000 12345E37 0
R 0F0 12345000 0
W 000 00001E97 0
R 0F4 0000104C 0
W 000 01000F6F 0
R 0F8 00000054 0
R 004 00000060 0
W 000 10008FE7 0
R 0FC 00000064 0
R 004 00000106 0
# beq taken, bne not taken, blt taken back, bgeu not taken
W 004 00000200 0
W 000 00108463 0
R 004 00000208 0
W 000 00109463 0
R 004 0000020C 0
W 000 FE114AE3 0
R 004 00000200 0
W 000 0020F463 0
R 004 00000204 0
R 000 0020F463 0
# x0 stays zero
W 080 DEADBEEF 0
R 080 00000000 0
W 000 00508013 0
R 080 00000000 0
R 004 00000208 0
# lw sw unknown mulhu and unmapped accesses
W 000 0000A283 1
W 000 00112023 1
W 000 FFFFFFFF 1
W 000 0220B2B3 1
W 008 00001234 1
R 100 00000000 1
R 004 00000208 0
R 094 00000000 0
R 084 00000007 0
R 000 00508013 0

// ==== test/rv_exec_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_exec_tb;
    import rv_pkg::*;

    localparam int ready_timeout = 20;

    logic        clk;
    logic        rst;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    word_t       pwdata;
    word_t       prdata;
    logic        pready;
    logic        pslverr;

    int          vectors;

    rv_exec_top rv_exec_top_i (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("Testbench failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // One setup cycle, then access until pready
    task automatic apb_transfer(input logic write, input logic [11:0] addr, input word_t data,
                                output word_t rdata, output logic err);
        int cycles;
        cycles = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(negedge clk); // Setup cycle, slave must stay quiet
        check_value("pready in setup", {31'b0, pready}, 32'h0);
        check_value("pslverr in setup", {31'b0, pslverr}, 32'h0);
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk); // Sample mid access cycle
        while (!pready && (cycles < ready_timeout)) begin
            cycles++;
            @(negedge clk);
        end
        if (!pready) begin
            $display("Timeout: the APB slave never became ready at address %h", addr);
            $display("Testbench failed");
            $fatal(1, "No pready within %0d cycles", ready_timeout);
        end else begin
            rdata = prdata;
            err   = pslverr;
            @(posedge clk); // State changes on this edge
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic run_vectors(input int fd, inout int count);
        int          ch;
        int          n;
        logic [7:0]  cmd;
        string       skip;
        logic [11:0] addr;
        word_t       data;
        word_t       rdata;
        logic        err_exp;
        logic        err;
        while (!$feof(fd)) begin
            ch  = $fgetc(fd);
            cmd = 8'(ch);
            if (cmd == "#") begin
                n = $fgets(skip, fd); // Comment line
            end else if ((cmd == "W") || (cmd == "R")) begin
                n = $fscanf(fd, " %h %h %h", addr, data, err_exp);
                if (n != 3) begin
                    $display("Malformed line in the stimulus file after %0d vectors", count);
                    $display("Testbench failed");
                    $fatal(1, "Bad stimulus line");
                end else begin
                    apb_transfer(cmd == "W", addr, data, rdata, err);
                    if (cmd == "R") begin
                        check_value($sformatf("prdata at %h", addr), rdata, data);
                    end
                    check_value($sformatf("pslverr at %h", addr), {31'b0, err}, {31'b0, err_exp});
                    count++;
                end
            end
        end
    endtask

    initial begin
        int fd;
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        vectors = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("test/rv_exec_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/rv_exec_stimulus.txt");
            $display("Testbench failed");
            $fatal(1, "No stimulus file");
        end else begin
            run_vectors(fd, vectors);
            $fclose(fd);
            if (vectors == 0) begin
                $display("The stimulus file held no vectors");
                $display("Testbench failed");
                $fatal(1, "Empty stimulus");
            end else begin
                $display("Testbench passed");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire
